//--- rtl/game_pkg.sv
package game_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Raster geometry

    // Horizontal, in pixels
    localparam int H_TOTAL  = 384;
    localparam int H_ACTIVE = 256;
    localparam int HS_START = 304;
    localparam int HS_END   = 335;

    // Vertical, in lines. Active lines run from 16 to 239
    localparam int V_TOTAL  = 264;
    localparam int VB_END   = 16;
    localparam int VB_START = 240;
    localparam int VS_START = 248;
    localparam int VS_END   = 251;

    ////////////////////////////////////////////////////////////////////////////
    // Clock enables, memories and download

    localparam int CEN_PERIOD = 24;
    localparam int CEN_CW     = $clog2(CEN_PERIOD);

    // 32x32 tile map, tile ROM is {code[9:0], row[2:0]}
    localparam int MAP_AW  = 10;
    localparam int CROM_AW = 13;
    localparam int PAL_AW  = 8;

    localparam logic [3:0] TRANSPARENT = 4'hF;

    // Region byte inside the program ROM
    localparam logic [11:0] JP_ADDR = 12'h041;
    localparam logic [ 7:0] JP_MARK = 8'h4A;

    // Palette number in the upper nibble, pixel value in the lower one
    localparam int CIDX_W = 8;
    typedef logic [CIDX_W-1:0] color_idx_t;

endpackage

//--- rtl/cen_gen.sv
`timescale 1ns/1ps

module cen_gen
    import game_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    output logic pxl_cen,
    output logic pxl2_cen,
    output logic cpu_cen
);

    logic [CEN_CW-1:0] cnt;
    logic [CEN_CW-1:0] cnt_nxt;

    // Single phase reference for all enables
    assign cnt_nxt = (cnt == CEN_CW'(CEN_PERIOD - 1)) ? '0 : cnt + 1'b1;

    // Enables are decoded from the next count so each pulse lines up
    // with the cycle in which the counter holds the matching value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt      <= '0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
            cpu_cen  <= 1'b0;
        end else begin
            cnt      <= cnt_nxt;
            // Every 4 cycles
            pxl2_cen <= cnt_nxt[1:0] == 2'd3;
            // Every 8 cycles
            pxl_cen  <= cnt_nxt[2:0] == 3'd7;
            // Every 6 cycles, 24 is a multiple of 6 so the wrap is seamless
            cpu_cen  <= (cnt_nxt % CEN_CW'(6)) == CEN_CW'(5);
        end
    end

endmodule

//--- rtl/video_timing.sv
`timescale 1ns/1ps

module video_timing
    import game_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pxl_cen,
    output logic [8:0] h,
    output logic [8:0] v,
    output logic       lhbl,
    output logic       lvbl,
    output logic       hs,
    output logic       vs
);

    logic [8:0] h_nxt;
    logic [8:0] v_nxt;
    logic       h_wrap;

    assign h_wrap = h == 9'(H_TOTAL - 1);

    always_comb begin
        h_nxt = h_wrap ? 9'd0 : h + 9'd1;
        v_nxt = v;
        if (h_wrap) begin
            v_nxt = (v == 9'(V_TOTAL - 1)) ? 9'd0 : v + 9'd1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Counters and windows
    //
    // Flags come from the next counter values, so h, v and every flag
    // move on the same edge

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h    <= 9'd0;
            v    <= 9'd0;
            lhbl <= 1'b0;
            lvbl <= 1'b0;
            hs   <= 1'b0;
            vs   <= 1'b0;
        end else if (pxl_cen) begin
            h    <= h_nxt;
            v    <= v_nxt;
            // Horizontal
            lhbl <= h_nxt < 9'(H_ACTIVE);
            hs   <= (h_nxt >= 9'(HS_START)) && (h_nxt <= 9'(HS_END));
            // Vertical
            lvbl <= (v_nxt >= 9'(VB_END)) && (v_nxt < 9'(VB_START));
            vs   <= (v_nxt >= 9'(VS_START)) && (v_nxt <= 9'(VS_END));
        end
    end

endmodule

//--- rtl/sync_ram.sv
`timescale 1ns/1ps

module sync_ram #(
    parameter type data_t = logic [7:0],
    parameter int  AW     = 8
) (
    input  logic          clk,
    input  logic          we,
    input  logic [AW-1:0] waddr,
    input  data_t         wdata,
    input  logic [AW-1:0] raddr,
    output data_t         rdata
);

    data_t mem [2**AW];

    // Read returns the old word on an address collision
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

//--- rtl/char_layer.sv
`timescale 1ns/1ps

// Map word: [13:10] palette, [9:0] tile code, [15:14] spare
module char_layer
    import game_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               pxl_cen,
    input  logic [8:0]         h,
    input  logic [8:0]         v,
    // CPU
    input  logic [MAP_AW:1]    cpu_addr,
    input  logic [15:0]        cpu_dout,
    input  logic               char_cs,
    input  logic               rnw,
    input  logic               udswn,
    input  logic               ldswn,
    output logic [15:0]        char_dout,
    output logic               char_busy,
    // Tile ROM
    output logic [CROM_AW-1:0] char_addr,
    output logic               char_rom_cs,
    input  logic [31:0]        char_data,
    input  logic               char_ok,
    output color_idx_t         pxl
);

    logic              pxl_cen_d;
    logic              fetch_slot;
    logic              fetch_d;
    logic              last_slot;
    logic [4:0]        fetch_col;
    logic [8:0]        v_draw;
    logic [MAP_AW-1:0] map_raddr;
    logic [7:0]        map_hi;
    logic [7:0]        map_lo;
    logic [15:0]       map_word;
    logic              cpu_rd;
    logic              cpu_port;
    logic              rd_done;
    logic              rd_first;
    logic [15:0]       dout_hold;
    logic [3:0]        req_pal;
    logic [3:0]        buf_pal;
    logic [3:0]        pend_pal;
    logic [3:0]        sh_pal;
    logic [31:0]       buf_data;
    logic [31:0]       pend_data;
    logic [31:0]       sh_data;

    ////////////////////////////////////////////////////////////////////////////
    // Map port arbitration

    // Video owns the read port right after h lands on a tile boundary
    assign fetch_slot = pxl_cen_d && (h[2:0] == 3'd0);

    // Last slot of a line prefetches column 0 for the next line
    assign last_slot = h[8:3] == 6'(H_TOTAL / 8 - 1);
    assign fetch_col = last_slot ? 5'd0 : h[7:3] + 5'd1;
    assign v_draw    = last_slot ? v + 9'd1 : v;

    assign map_raddr = fetch_slot ? {v_draw[7:3], fetch_col} : cpu_addr;
    assign map_word  = {map_hi, map_lo};

    assign cpu_rd    = char_cs & rnw;
    assign cpu_port  = cpu_rd & ~rd_done & ~fetch_slot;
    assign char_busy = cpu_rd & ~rd_done;
    assign char_dout = rd_first ? map_word : dout_hold;

    // One RAM per byte lane, strobes are active low
    sync_ram #(.data_t(logic [7:0]), .AW(MAP_AW)) u_map_hi (
        .clk   ( clk                        ),
        .we    ( char_cs & ~rnw & ~udswn    ),
        .waddr ( cpu_addr                   ),
        .wdata ( cpu_dout[15:8]             ),
        .raddr ( map_raddr                  ),
        .rdata ( map_hi                     )
    );

    sync_ram #(.data_t(logic [7:0]), .AW(MAP_AW)) u_map_lo (
        .clk   ( clk                        ),
        .we    ( char_cs & ~rnw & ~ldswn    ),
        .waddr ( cpu_addr                   ),
        .wdata ( cpu_dout[7:0]              ),
        .raddr ( map_raddr                  ),
        .rdata ( map_lo                     )
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pxl_cen_d   <= 1'b0;
            fetch_d     <= 1'b0;
            rd_first    <= 1'b0;
            rd_done     <= 1'b0;
            char_rom_cs <= 1'b0;
            char_addr   <= '0;
        end else begin
            pxl_cen_d <= pxl_cen;
            fetch_d   <= fetch_slot;
            rd_first  <= cpu_port;
            // Stays set until the CPU lets go of char_cs
            rd_done   <= cpu_rd & (rd_done | cpu_port);
            // A new tile request wins over a completing one
            if (fetch_d) begin
                char_rom_cs <= 1'b1;
                char_addr   <= {map_word[CROM_AW-4:0], v_draw[2:0]};
            end else if (char_ok) begin
                char_rom_cs <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Row buffers and pixel shifter

    always_ff @(posedge clk) begin
        if (rd_first) begin
            dout_hold <= map_word;
        end
        if (fetch_d) begin
            req_pal <= map_word[13:10];
        end
        if (char_rom_cs && char_ok) begin
            buf_data <= char_data;
            buf_pal  <= req_pal;
        end
        // A late ROM answer leaves the previous tile in place
        if (fetch_slot) begin
            pend_data <= buf_data;
            pend_pal  <= buf_pal;
        end
        // New tile enters as h steps to 8t+7, one tile behind the raster
        if (pxl_cen) begin
            if (h[2:0] == 3'd6) begin
                sh_data <= pend_data;
                sh_pal  <= pend_pal;
            end else begin
                sh_data <= sh_data << 4;
            end
        end
    end

    // Leftmost pixel sits in the top nibble
    assign pxl = {sh_pal, sh_data[31:28]};

endmodule

//--- rtl/prom_loader.sv
`timescale 1ns/1ps

module prom_loader
    import game_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [11:0]       prog_addr,
    input  logic [7:0]        prog_data,
    input  logic              prog_we,
    input  logic              prom_we,
    output logic [2:0]        pal_we,
    output logic [PAL_AW-1:0] pal_addr,
    output logic [3:0]        pal_din,
    output logic              region_jp
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pal_we    <= 3'b000;
            region_jp <= 1'b0;
        end else begin
            pal_we <= 3'b000;
            // Bits 9:8 pick red, green or blue, the fourth region is dropped
            if (prom_we) begin
                case (prog_addr[9:8])
                    2'd0:    pal_we <= 3'b001;
                    2'd1:    pal_we <= 3'b010;
                    2'd2:    pal_we <= 3'b100;
                    default: pal_we <= 3'b000;
                endcase
            end
            if (prog_we && (prog_addr == JP_ADDR)) begin
                region_jp <= prog_data == JP_MARK;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (prom_we) begin
            pal_addr <= prog_addr[PAL_AW-1:0];
            pal_din  <= prog_data[3:0];
        end
    end

endmodule

//--- rtl/color_mix.sv
`timescale 1ns/1ps

module color_mix
    import game_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pxl_cen,
    input  color_idx_t        pxl,
    input  logic              lhbl,
    input  logic              lvbl,
    input  logic [2:0]        pal_we,
    input  logic [PAL_AW-1:0] pal_addr,
    input  logic [3:0]        pal_din,
    output logic [3:0]        red,
    output logic [3:0]        green,
    output logic [3:0]        blue
);

    logic [3:0] pal_q [3];
    logic [3:0] rgb_q [3];
    logic [7:0] lhbl_sr;
    logic       win;

    // Red, green and blue PROMs share the lookup address
    for (genvar k = 0; k < 3; k++) begin : g_prom
        sync_ram #(.data_t(logic [3:0]), .AW(PAL_AW)) u_prom (
            .clk   ( clk        ),
            .we    ( pal_we[k]  ),
            .waddr ( pal_addr   ),
            .wdata ( pal_din    ),
            .raddr ( pxl        ),
            .rdata ( pal_q[k]   )
        );
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lhbl_sr <= 8'd0;
            for (int k = 0; k < 3; k++) begin
                rgb_q[k] <= 4'h0;
            end
        end else if (pxl_cen) begin
            // Blanking delayed by the one-tile layer latency
            lhbl_sr <= {lhbl_sr[6:0], lhbl};
            for (int k = 0; k < 3; k++) begin
                rgb_q[k] <= (pxl[3:0] == TRANSPARENT) ? 4'h0 : pal_q[k];
            end
        end
    end

    // Visible for 8 <= h < 256 on active lines
    assign win   = lhbl & lhbl_sr[7] & lvbl;
    assign red   = win ? rgb_q[0] : 4'h0;
    assign green = win ? rgb_q[1] : 4'h0;
    assign blue  = win ? rgb_q[2] : 4'h0;

endmodule

//--- rtl/arcade_game.sv
`timescale 1ns/1ps

module arcade_game
    import game_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    // CPU
    input  logic [MAP_AW:1]    cpu_addr,
    input  logic [15:0]        cpu_dout,
    input  logic               char_cs,
    input  logic               rnw,
    input  logic               udswn,
    input  logic               ldswn,
    output logic [15:0]        char_dout,
    output logic               char_busy,
    // Tile ROM
    output logic [CROM_AW-1:0] char_addr,
    output logic               char_rom_cs,
    input  logic [31:0]        char_data,
    input  logic               char_ok,
    // Download
    input  logic [11:0]        prog_addr,
    input  logic [7:0]         prog_data,
    input  logic               prog_we,
    input  logic               prom_we,
    // Video
    output logic               pxl_cen,
    output logic               pxl2_cen,
    output logic               cpu_cen,
    output logic [8:0]         h,
    output logic [8:0]         v,
    output logic               lhbl,
    output logic               lvbl,
    output logic               hs,
    output logic               vs,
    output logic [3:0]         red,
    output logic [3:0]         green,
    output logic [3:0]         blue,
    output logic               region_jp
);

    color_idx_t        char_pxl;
    logic [2:0]        pal_we;
    logic [PAL_AW-1:0] pal_addr;
    logic [3:0]        pal_din;

    ////////////////////////////////////////////////////////////////////////////
    // Timing

    cen_gen u_cen (
        .clk      ( clk       ),
        .rst_n    ( rst_n     ),
        .pxl_cen  ( pxl_cen   ),
        .pxl2_cen ( pxl2_cen  ),
        .cpu_cen  ( cpu_cen   )
    );

    video_timing u_timing (
        .clk      ( clk       ),
        .rst_n    ( rst_n     ),
        .pxl_cen  ( pxl_cen   ),
        .h        ( h         ),
        .v        ( v         ),
        .lhbl     ( lhbl      ),
        .lvbl     ( lvbl      ),
        .hs       ( hs        ),
        .vs       ( vs        )
    );

    ////////////////////////////////////////////////////////////////////////////
    // Video layers and colour

    char_layer u_char (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .pxl_cen     ( pxl_cen     ),
        .h           ( h           ),
        .v           ( v           ),
        .cpu_addr    ( cpu_addr    ),
        .cpu_dout    ( cpu_dout    ),
        .char_cs     ( char_cs     ),
        .rnw         ( rnw         ),
        .udswn       ( udswn       ),
        .ldswn       ( ldswn       ),
        .char_dout   ( char_dout   ),
        .char_busy   ( char_busy   ),
        .char_addr   ( char_addr   ),
        .char_rom_cs ( char_rom_cs ),
        .char_data   ( char_data   ),
        .char_ok     ( char_ok     ),
        .pxl         ( char_pxl    )
    );

    // Palette PROMs arrive through the download stream
    prom_loader u_loader (
        .clk       ( clk        ),
        .rst_n     ( rst_n      ),
        .prog_addr ( prog_addr  ),
        .prog_data ( prog_data  ),
        .prog_we   ( prog_we    ),
        .prom_we   ( prom_we    ),
        .pal_we    ( pal_we     ),
        .pal_addr  ( pal_addr   ),
        .pal_din   ( pal_din    ),
        .region_jp ( region_jp  )
    );

    color_mix u_colmix (
        .clk      ( clk       ),
        .rst_n    ( rst_n     ),
        .pxl_cen  ( pxl_cen   ),
        .pxl      ( char_pxl  ),
        .lhbl     ( lhbl      ),
        .lvbl     ( lvbl      ),
        .pal_we   ( pal_we    ),
        .pal_addr ( pal_addr  ),
        .pal_din  ( pal_din   ),
        .red      ( red       ),
        .green    ( green     ),
        .blue     ( blue      )
    );

endmodule

//--- tb/tb_arcade_game.sv
`timescale 1ns/1ps

module tb_arcade_game
    import game_pkg::*;
;

    localparam logic [31:0] SEED = 32'hb5682ffa;
    localparam int RD_TIMEOUT    = 4;
    localparam int FRAME_TIMEOUT = 900000;

    logic        clk;
    logic        rst_n;
    logic [10:1] cpu_addr;
    logic [15:0] cpu_dout;
    logic        char_cs;
    logic        rnw;
    logic        udswn;
    logic        ldswn;
    logic [15:0] char_dout;
    logic        char_busy;
    logic [12:0] char_addr;
    logic        char_rom_cs;
    logic [31:0] char_data;
    logic        char_ok;
    logic [11:0] prog_addr;
    logic [7:0]  prog_data;
    logic        prog_we;
    logic        prom_we;
    logic        pxl_cen;
    logic        pxl2_cen;
    logic        cpu_cen;
    logic [8:0]  h;
    logic [8:0]  v;
    logic        lhbl;
    logic        lvbl;
    logic        hs;
    logic        vs;
    logic [3:0]  red;
    logic [3:0]  green;
    logic [3:0]  blue;
    logic        region_jp;

    // Shadow copies of the map and the three palette PROMs
    logic [15:0] map_sh [1024];
    logic [3:0]  pal_r [256];
    logic [3:0]  pal_g [256];
    logic [3:0]  pal_b [256];

    int          cyc;
    int          mism_cnt;
    int          fail_cnt;
    logic [2:0]  exp_cen;
    logic [8:0]  exp_h;
    logic [8:0]  exp_v;
    logic [3:0]  exp_flags;
    logic [11:0] exp_rgb;
    int          exp_caddr;
    logic        exp_jp;
    logic [15:0] rd_exp;
    logic        rd_new;
    logic        render_on;

    arcade_game dut (
        .clk(clk), .rst_n(rst_n),
        .cpu_addr(cpu_addr), .cpu_dout(cpu_dout), .char_cs(char_cs), .rnw(rnw),
        .udswn(udswn), .ldswn(ldswn), .char_dout(char_dout), .char_busy(char_busy),
        .char_addr(char_addr), .char_rom_cs(char_rom_cs), .char_data(char_data),
        .char_ok(char_ok), .prog_addr(prog_addr), .prog_data(prog_data),
        .prog_we(prog_we), .prom_we(prom_we), .pxl_cen(pxl_cen), .pxl2_cen(pxl2_cen),
        .cpu_cen(cpu_cen), .h(h), .v(v), .lhbl(lhbl), .lvbl(lvbl), .hs(hs), .vs(vs),
        .red(red), .green(green), .blue(blue), .region_jp(region_jp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Tile ROM contents as a fixed scramble of the address
    function automatic logic [31:0] rom_word(input logic [12:0] a);
        logic [31:0] x;
        x = {19'd0, a} * 32'h9E37_79B1;
        return x ^ {x[15:0], x[31:16]};
    endfunction

    // Colour expected on screen while the raster sits at (hx, vy)
    function automatic logic [11:0] screen_rgb(input int hx, input int vy);
        int          col;
        logic [15:0] ent;
        logic [31:0] rw;
        logic [3:0]  pix;
        logic [7:0]  idx;
        if (hx < 8 || hx >= H_ACTIVE || vy < VB_END || vy >= VB_START) begin
            return 12'h000;
        end
        col = hx - 8;
        ent = map_sh[(vy / 8) * 32 + col / 8];
        rw  = rom_word({ent[9:0], 3'(vy % 8)});
        pix = rw[31 - 4 * (col % 8) -: 4];
        if (pix == TRANSPARENT) begin
            return 12'h000;
        end
        idx = {ent[13:10], pix};
        return {pal_r[idx], pal_g[idx], pal_b[idx]};
    endfunction

    // Tile ROM address requested while the raster sits at (hx, vy)
    // -1 where the fetched tile never reaches the screen
    function automatic int fetch_addr(input int hx, input int vy);
        int          row;
        int          col;
        logic [15:0] ent;
        row = vy;
        col = hx / 8 + 1;
        // Last slot of a line prefetches column 0 of the next line
        if (hx == H_TOTAL - 8) begin
            row = vy + 1;
            col = 0;
        end
        if (col > 31 || row > 255) begin
            return -1;
        end
        ent = map_sh[(row / 8) * 32 + col];
        return int'({ent[9:0], 3'(row % 8)});
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model one step ahead so it holds the post-edge state

    always @(posedge clk or negedge rst_n) begin : ref_model
        int k;
        int n;
        int hx;
        int vy;
        if (!rst_n) begin
            cyc       <= 0;
            exp_cen   <= 3'b000;
            exp_h     <= 9'd0;
            exp_v     <= 9'd0;
            exp_flags <= 4'b0000;
            exp_rgb   <= 12'h000;
            exp_caddr <= -1;
            exp_jp    <= 1'b0;
        end else begin
            k  = cyc + 1;
            // Raster steps once per 8 clocks
            n  = k / 8;
            hx = n % H_TOTAL;
            vy = (n / H_TOTAL) % V_TOTAL;
            cyc     <= k;
            exp_cen <= {(k % 8) == 7, (k % 4) == 3, (k % 6) == 5};
            exp_h   <= 9'(hx);
            exp_v   <= 9'(vy);
            // lhbl, lvbl, hs, vs
            exp_flags <= {(n > 0) && (hx < H_ACTIVE),
                          (vy >= VB_END) && (vy < VB_START),
                          (hx >= HS_START) && (hx <= HS_END),
                          (vy >= VS_START) && (vy <= VS_END)};
            exp_rgb   <= screen_rgb(hx, vy);
            exp_caddr <= fetch_addr(hx, vy);
            if (prog_we && prog_addr == JP_ADDR) begin
                exp_jp <= prog_data == JP_MARK;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks sampled on the falling edge

    enables_chk: assert property (@(negedge clk) {pxl_cen, pxl2_cen, cpu_cen} == exp_cen)
        else begin
            mism_cnt++;
            $display("MISMATCH enables: expected %b actual %b", exp_cen,
                     {pxl_cen, pxl2_cen, cpu_cen});
        end

    raster_chk: assert property (@(negedge clk)
            {h, v, lhbl, lvbl, hs, vs} == {exp_h, exp_v, exp_flags})
        else begin
            mism_cnt++;
            $display("MISMATCH raster: expected h=%0d v=%0d flags=%b actual h=%0d v=%0d flags=%b",
                     exp_h, exp_v, exp_flags, h, v, {lhbl, lvbl, hs, vs});
        end

    region_chk: assert property (@(negedge clk) region_jp == exp_jp)
        else begin
            mism_cnt++;
            $display("MISMATCH region_jp: expected %b actual %b", exp_jp, region_jp);
        end

    write_busy_chk: assert property (@(negedge clk) (char_cs && !rnw) |-> !char_busy)
        else begin
            mism_cnt++;
            $display("MISMATCH write_busy: expected 0 actual %b", char_busy);
        end

    read_busy_chk: assert property (@(negedge clk) rd_new |-> char_busy)
        else begin
            mism_cnt++;
            $display("MISMATCH read_busy: expected 1 actual %b", char_busy);
        end

    read_data_chk: assert property (@(negedge clk)
            (char_cs && rnw && !char_busy) |-> (char_dout == rd_exp))
        else begin
            mism_cnt++;
            $display("MISMATCH cpu_read @%03h: expected %04h actual %04h",
                     cpu_addr, rd_exp, char_dout);
        end

    rom_addr_chk: assert property (@(negedge clk)
            (render_on && $rose(char_rom_cs) && exp_caddr >= 0)
            |-> (char_addr == 13'(exp_caddr)))
        else begin
            mism_cnt++;
            $display("MISMATCH rom_addr h=%0d v=%0d: expected %04h actual %04h",
                     exp_h, exp_v, 13'(exp_caddr), char_addr);
        end

    // A request stays up until the ROM answers, then drops
    rom_cs_chk: assert property (@(negedge clk)
            $past(char_rom_cs) |-> (char_rom_cs == !$past(char_ok)))
        else begin
            mism_cnt++;
            $display("MISMATCH rom_cs: expected %b actual %b", !char_rom_cs, char_rom_cs);
        end

    render_chk: assert property (@(negedge clk) render_on |-> ({red, green, blue} == exp_rgb))
        else begin
            mism_cnt++;
            $display("MISMATCH render x=%0d y=%0d: expected %03h actual %03h",
                     exp_h, exp_v, exp_rgb, {red, green, blue});
        end

    ////////////////////////////////////////////////////////////////////////////
    // Tile ROM with 0 to 3 cycles of latency

    initial begin : rom_model
        int   left;
        logic pending;
        left      = 0;
        pending   = 1'b0;
        char_ok   = 1'b0;
        char_data = 32'd0;
        forever begin
            @(posedge clk);
            #1;
            if (char_ok) begin
                char_ok = 1'b0;
                pending = 1'b0;
            end else if (char_rom_cs) begin
                if (!pending) begin
                    pending = 1'b1;
                    left    = $urandom_range(3, 0);
                end
                if (left == 0) begin
                    char_ok   = 1'b1;
                    char_data = rom_word(char_addr);
                end else begin
                    left = left - 1;
                end
            end
        end
    end

    // Tasks start and return 1 ns after a rising edge
    task automatic prom_write(input logic [1:0] region, input logic [7:0] idx,
                              input logic [7:0] d);
        prog_addr = {2'b00, region, idx};
        prog_data = d;
        prom_we   = 1'b1;
        case (region)
            2'd0:    pal_r[idx] = d[3:0];
            2'd1:    pal_g[idx] = d[3:0];
            2'd2:    pal_b[idx] = d[3:0];
            default: ;
        endcase
        @(posedge clk);
        #1;
        prom_we = 1'b0;
    endtask

    task automatic prog_write(input logic [11:0] a, input logic [7:0] d);
        prog_addr = a;
        prog_data = d;
        prog_we   = 1'b1;
        @(posedge clk);
        #1;
        prog_we = 1'b0;
    endtask

    // lanes[1] is the upper byte and lanes[0] the lower one
    task automatic map_write(input logic [9:0] a, input logic [15:0] d,
                             input logic [1:0] lanes);
        cpu_addr = a;
        cpu_dout = d;
        rnw      = 1'b0;
        udswn    = !lanes[1];
        ldswn    = !lanes[0];
        char_cs  = 1'b1;
        if (lanes[1]) map_sh[a][15:8] = d[15:8];
        if (lanes[0]) map_sh[a][7:0] = d[7:0];
        @(posedge clk);
        #1;
        char_cs = 1'b0;
        rnw     = 1'b1;
        udswn   = 1'b1;
        ldswn   = 1'b1;
    endtask

    task automatic map_read(input logic [9:0] a);
        int t;
        cpu_addr = a;
        rnw      = 1'b1;
        rd_exp   = map_sh[a];
        rd_new   = 1'b1;
        char_cs  = 1'b1;
        t        = 0;
        @(posedge clk);
        #1;
        rd_new = 1'b0;
        while (char_busy && t < RD_TIMEOUT) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (char_busy) begin
            fail_cnt++;
            $display("CPU read at %03h: char_busy did not fall in time", a);
        end
        // Data is checked on this falling edge
        @(posedge clk);
        #1;
        char_cs = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic wait_line(input int line);
        int t;
        t = 0;
        while (!(v == 9'(line) && h == 9'd0) && t < FRAME_TIMEOUT) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (!(v == 9'(line) && h == 9'd0)) begin
            fail_cnt++;
            $display("Timed out waiting for the start of line %0d", line);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus

    initial begin
        void'($urandom(SEED));
        mism_cnt  = 0;
        fail_cnt  = 0;
        rst_n     = 1'b0;
        cpu_addr  = '0;
        cpu_dout  = 16'd0;
        char_cs   = 1'b0;
        rnw       = 1'b1;
        udswn     = 1'b1;
        ldswn     = 1'b1;
        prog_addr = 12'd0;
        prog_data = 8'd0;
        prog_we   = 1'b0;
        prom_we   = 1'b0;
        rd_exp    = 16'd0;
        rd_new    = 1'b0;
        render_on = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Palettes followed by region 3 writes that must leave them alone
        for (int r = 0; r < 4; r++) begin
            for (int i = 0; i < 256; i++) begin
                prom_write(2'(r), 8'(i), 8'($urandom));
            end
        end

        // Region byte
        prog_write(JP_ADDR, JP_MARK);
        prog_write(12'h042, 8'h00);
        prog_write(JP_ADDR, 8'h4B);
        prog_write(12'h141, JP_MARK);
        prog_write(JP_ADDR, JP_MARK);

        for (int i = 0; i < 1024; i++) begin
            map_write(10'(i), 16'($urandom), 2'b11);
        end

        // Byte-lane writes each read back at once
        for (int j = 0; j < 48; j++) begin
            logic [9:0] a;
            a = 10'($urandom);
            map_write(a, 16'($urandom), 2'((j % 3) + 1));
            map_read(a);
        end

        // One full frame of rendering with CPU reads during active lines
        wait_line(0);
        render_on = 1'b1;
        wait_line(100);
        for (int j = 0; j < 64; j++) begin
            map_read(10'($urandom));
        end
        wait_line(V_TOTAL - 1);
        wait_line(0);
        render_on = 1'b0;
        repeat (4) @(posedge clk);

        $display("Errors: %0d mismatches, %0d other failures", mism_cnt, fail_cnt);
        if (mism_cnt == 0 && fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- build.f
rtl/game_pkg.sv
rtl/cen_gen.sv
rtl/video_timing.sv
rtl/sync_ram.sv
rtl/char_layer.sv
rtl/prom_loader.sv
rtl/color_mix.sv
rtl/arcade_game.sv
tb/tb_arcade_game.sv

//--- run.sh
#!/bin/sh
# Compile and run the testbench with Verilator, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_arcade_game \
    -f build.f -o tb_sim || { echo "Verilator build failed"; exit 1; }

out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -qx "TEST RESULT: PASS" && exit 0 || exit 1
